// File: design/stream_cfg.svh
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// sample and gain widths
`define STREAM_SAMPLE_W 16
`define STREAM_GAIN_W 8
`define STREAM_GAIN_FRAC 4

// gain of 1.0 in the fixed-point format
`define STREAM_GAIN_ONE (1 << `STREAM_GAIN_FRAC)

// signed sample times zero-extended gain
`define STREAM_PROD_W (`STREAM_SAMPLE_W + `STREAM_GAIN_W + 1)
`define STREAM_CFG_W 16

`endif

// File: design/stream_pkg.sv
`include "stream_cfg.svh"

package stream_pkg;

	// one signed sample
	typedef logic signed [`STREAM_SAMPLE_W-1:0] sample_t;

	// scaler result, flag set when the value was clamped
	typedef struct packed {
		sample_t value;
		logic    sat;
	} scaled_t;

	// register map
	typedef enum logic [1:0] {
		ADDR_GAIN   = 2'd0,
		ADDR_OFFSET = 2'd1,
		ADDR_CTRL   = 2'd2,
		ADDR_SATCNT = 2'd3
	} cfg_addr_t;

endpackage

// File: design/skidbuffer.sv
`include "stream_cfg.svh"

module skidbuffer
	import stream_pkg::*;
#(
	parameter type T = sample_t
) (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_valid,
	output logic o_ready,
	input  T     i_data,
	output logic o_valid,
	input  logic i_ready,
	output T     o_data
);

	// side register, holds one word while the output is stalled
	logic skid_valid;
	T     skid_data;
	logic out_valid;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			skid_valid <= 1'b0;
		end
		else if (i_valid && o_ready && o_valid && !i_ready)
		begin
			// incoming word with nowhere to go
			skid_valid <= 1'b1;
		end
		else if (i_ready)
		begin
			skid_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (o_ready)
		begin
			skid_data <= i_data;
		end
	end

	// ready only depends on local state
	assign o_ready = !skid_valid;

	// registered output stage
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			out_valid <= 1'b0;
		end
		else if (!out_valid || i_ready)
		begin
			out_valid <= i_valid || skid_valid;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (!out_valid || i_ready)
		begin
			// side word goes first to keep order
			if (skid_valid)
			begin
				o_data <= skid_data;
			end
			else
			begin
				o_data <= i_data;
			end
		end
	end

	assign o_valid = out_valid;

	// a stalled output must not move
	a_stall_stable: assert property (
		@(posedge i_clk) disable iff (i_reset)
		o_valid && !i_ready |=> o_valid && $stable(o_data)
	);

	// a full side register means the output is also holding a word
	a_skid_full: assert property (
		@(posedge i_clk) disable iff (i_reset)
		skid_valid |-> !o_ready && o_valid
	);

endmodule

// File: design/sample_scaler.sv
`include "stream_cfg.svh"

module sample_scaler
	import stream_pkg::*;
(
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_valid,
	output logic                      o_ready,
	input  sample_t                   i_data,
	output logic                      o_valid,
	input  logic                      i_ready,
	output scaled_t                   o_data,
	input  logic [`STREAM_GAIN_W-1:0] i_gain,
	input  sample_t                   i_offset,
	input  logic                      i_enable,
	output logic                      o_sat_event
);

	localparam int W = `STREAM_SAMPLE_W;
	localparam int PROD_W = `STREAM_PROD_W;
	localparam int SUM_W = PROD_W + 1;
	localparam logic signed [SUM_W-1:0] SAT_MAX = {{(SUM_W-W+1){1'b0}}, {(W-1){1'b1}}};
	localparam logic signed [SUM_W-1:0] SAT_MIN = {{(SUM_W-W+1){1'b1}}, {(W-1){1'b0}}};

	logic                     s1_valid;
	logic signed [PROD_W-1:0] s1_prod;
	sample_t                  s1_sample;
	logic                     s2_valid;
	logic                     s1_adv;
	logic                     s2_adv;
	logic signed [PROD_W-1:0] shifted;
	logic signed [SUM_W-1:0]  sum;
	scaled_t                  result;

	// a stage moves when the next one is empty or draining
	assign s2_adv = !s2_valid || i_ready;
	assign s1_adv = !s1_valid || s2_adv;
	assign o_ready = s1_adv;

	// stage one, multiply
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			s1_valid <= 1'b0;
		end
		else if (s1_adv)
		begin
			s1_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (s1_adv)
		begin
			s1_prod <= i_data * $signed({1'b0, i_gain});
			s1_sample <= i_data;
		end
	end

	// stage two, shift, add offset, clamp
	assign shifted = s1_prod >>> `STREAM_GAIN_FRAC;
	assign sum = shifted + i_offset;

	always_comb
	begin
		result.value = sum[W-1:0];
		result.sat = 1'b0;
		if (!i_enable)
		begin
			result.value = s1_sample;
		end
		else if (sum > SAT_MAX)
		begin
			result.value = {1'b0, {(W-1){1'b1}}};
			result.sat = 1'b1;
		end
		else if (sum < SAT_MIN)
		begin
			result.value = {1'b1, {(W-1){1'b0}}};
			result.sat = 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			s2_valid <= 1'b0;
		end
		else if (s2_adv)
		begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (s2_adv)
		begin
			o_data <= result;
		end
	end

	assign o_valid = s2_valid;
	assign o_sat_event = o_valid && i_ready && o_data.sat;

	// saturation can only come out of the scaling path, never bypass
	a_sat_event: assert property (
		@(posedge i_clk) disable iff (i_reset)
		o_sat_event |-> o_valid && i_ready && i_enable
	);

endmodule

// File: design/scaler_regs.sv
`include "stream_cfg.svh"

module scaler_regs
	import stream_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_cfg_we,
	input  cfg_addr_t                i_cfg_addr,
	input  logic [`STREAM_CFG_W-1:0] i_cfg_wdata,
	output logic [`STREAM_CFG_W-1:0] o_cfg_rdata,
	input  logic                     i_sat_event,
	output logic [`STREAM_GAIN_W-1:0] o_gain,
	output sample_t                  o_offset,
	output logic                     o_enable
);

	logic [`STREAM_CFG_W-1:0] sat_cnt;
	logic                     sat_clr;

	assign sat_clr = i_cfg_we && (i_cfg_addr == ADDR_SATCNT);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_gain <= `STREAM_GAIN_W'(`STREAM_GAIN_ONE);
			o_offset <= '0;
			o_enable <= 1'b0;
		end
		else if (i_cfg_we)
		begin
			case (i_cfg_addr)
				ADDR_GAIN:   o_gain <= i_cfg_wdata[`STREAM_GAIN_W-1:0];
				ADDR_OFFSET: o_offset <= i_cfg_wdata;
				ADDR_CTRL:   o_enable <= i_cfg_wdata[0];
				default:     ;
			endcase
		end
	end

	// saturating event counter, a clearing write wins over an event
	always_ff @(posedge i_clk)
	begin
		if (i_reset || sat_clr)
		begin
			sat_cnt <= '0;
		end
		else if (i_sat_event && (sat_cnt != '1))
		begin
			sat_cnt <= sat_cnt + 1'b1;
		end
	end

	always_comb
	begin
		case (i_cfg_addr)
			ADDR_GAIN:   o_cfg_rdata = {{(`STREAM_CFG_W-`STREAM_GAIN_W){1'b0}}, o_gain};
			ADDR_OFFSET: o_cfg_rdata = o_offset;
			ADDR_CTRL:   o_cfg_rdata = {{(`STREAM_CFG_W-1){1'b0}}, o_enable};
			default:     o_cfg_rdata = sat_cnt;
		endcase
	end

	a_cnt_monotonic: assert property (
		@(posedge i_clk) disable iff (i_reset)
		!sat_clr |=> sat_cnt >= $past(sat_cnt)
	);

endmodule

// File: design/scaler_top.sv
`include "stream_cfg.svh"

module scaler_top
	import stream_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_valid,
	output logic                     o_ready,
	input  sample_t                  i_data,
	output logic                     o_valid,
	input  logic                     i_ready,
	output scaled_t                  o_data,
	input  logic                     i_cfg_we,
	input  cfg_addr_t                i_cfg_addr,
	input  logic [`STREAM_CFG_W-1:0] i_cfg_wdata,
	output logic [`STREAM_CFG_W-1:0] o_cfg_rdata
);

	logic                      in_valid;
	logic                      in_ready;
	sample_t                   in_data;
	logic                      sc_valid;
	logic                      sc_ready;
	scaled_t                   sc_data;
	logic [`STREAM_GAIN_W-1:0] gain;
	sample_t                   offset;
	logic                      enable;
	logic                      sat_event;

	// input side buffer
	skidbuffer #(
		.T(sample_t)
	) in_skid_i (
		.i_clk  (i_clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.o_ready(o_ready),
		.i_data (i_data),
		.o_valid(in_valid),
		.i_ready(in_ready),
		.o_data (in_data)
	);

	sample_scaler sample_scaler_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_valid    (in_valid),
		.o_ready    (in_ready),
		.i_data     (in_data),
		.o_valid    (sc_valid),
		.i_ready    (sc_ready),
		.o_data     (sc_data),
		.i_gain     (gain),
		.i_offset   (offset),
		.i_enable   (enable),
		.o_sat_event(sat_event)
	);

	scaler_regs scaler_regs_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_cfg_we   (i_cfg_we),
		.i_cfg_addr (i_cfg_addr),
		.i_cfg_wdata(i_cfg_wdata),
		.o_cfg_rdata(o_cfg_rdata),
		.i_sat_event(sat_event),
		.o_gain     (gain),
		.o_offset   (offset),
		.o_enable   (enable)
	);

	// output side buffer, receiver may stall here
	skidbuffer #(
		.T(scaled_t)
	) out_skid_i (
		.i_clk  (i_clk),
		.i_reset(i_reset),
		.i_valid(sc_valid),
		.o_ready(sc_ready),
		.i_data (sc_data),
		.o_valid(o_valid),
		.i_ready(i_ready),
		.o_data (o_data)
	);

endmodule

// File: dv/scaler_tb.sv
`include "stream_cfg.svh"

module scaler_tb
	import stream_pkg::*;
();

	logic                     i_clk;
	logic                     i_reset;
	logic                     i_valid;
	logic                     o_ready;
	sample_t                  i_data;
	logic                     o_valid;
	logic                     i_ready = 1'b1;
	scaled_t                  o_data;
	logic                     i_cfg_we;
	cfg_addr_t                i_cfg_addr;
	logic [`STREAM_CFG_W-1:0] i_cfg_wdata;
	logic [`STREAM_CFG_W-1:0] o_cfg_rdata;

	integer  seed;
	scaled_t exp_q[$];
	scaled_t exp_head = '0;
	scaled_t new_exp;
	int      q_count = 0;
	int      n_in = 0;
	int      n_out = 0;
	int      n_err = 0;
	int      n_tests = 0;
	int      errs_at_start = 0;
	int      exp_sat = 0;
	int      cyc = 0;
	int      acc_cyc = 0;
	int      out_cyc = 0;
	int      i;
	int      k;

	// model copy of the register state
	logic [`STREAM_GAIN_W-1:0] cfg_gain = `STREAM_GAIN_W'(`STREAM_GAIN_ONE);
	sample_t                   cfg_offset = '0;
	logic                      cfg_en = 1'b0;

	logic                     bp_mode = 1'b0;
	logic                     bp_now;
	logic                     rd_en = 1'b0;
	logic [`STREAM_CFG_W-1:0] rd_exp = '0;
	logic                     cmp_en = 1'b0;
	string                    cmp_name = "";
	int                       cmp_exp = 0;
	int                       cmp_got = 0;

	logic [`STREAM_CFG_W-1:0] gains [4] = '{16'h0010, 16'h0028, 16'h0007, 16'h00c8};
	logic [`STREAM_CFG_W-1:0] offsets [4] = '{16'h0064, 16'hfe0c, 16'h04d2, 16'h0000};
	sample_t extremes [8] = '{16'sh7fff, 16'sd2000, 16'sd0, 16'sd30000,
		16'sh8000, -16'sd3000, 16'sd0, -16'sd30000};

	scaler_top scaler_top_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_valid    (i_valid),
		.o_ready    (o_ready),
		.i_data     (i_data),
		.o_valid    (o_valid),
		.i_ready    (i_ready),
		.o_data     (o_data),
		.i_cfg_we   (i_cfg_we),
		.i_cfg_addr (i_cfg_addr),
		.i_cfg_wdata(i_cfg_wdata),
		.o_cfg_rdata(o_cfg_rdata)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// multiply by gain, drop the fraction, add offset, clamp
	function automatic scaled_t model(sample_t s);
		longint  v;
		longint  hi;
		scaled_t r;
		hi = (longint'(1) <<< (`STREAM_SAMPLE_W - 1)) - 1;
		v = (longint'(s) * longint'(cfg_gain)) >>> `STREAM_GAIN_FRAC;
		v = v + longint'(cfg_offset);
		r.value = sample_t'(v);
		r.sat = 1'b0;
		if (!cfg_en)
		begin
			r.value = s;
		end
		else if (v > hi)
		begin
			r.value = sample_t'(hi);
			r.sat = 1'b1;
		end
		else if (v < -hi - 1)
		begin
			r.value = sample_t'(-hi - 1);
			r.sat = 1'b1;
		end
		return r;
	endfunction

	// scoreboard bookkeeping, transfers seen at the clock edge
	always @(posedge i_clk)
	begin
		cyc = cyc + 1;
		if (!i_reset)
		begin
			if (o_valid && i_ready)
			begin
				if (exp_q.size() > 0)
				begin
					exp_q.delete(0);
				end
				n_out = n_out + 1;
				out_cyc = cyc;
			end
			if (i_valid && o_ready)
			begin
				new_exp = model(i_data);
				exp_q.push_back(new_exp);
				if (new_exp.sat)
				begin
					exp_sat = exp_sat + 1;
				end
				n_in = n_in + 1;
				acc_cyc = cyc;
			end
			exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
			q_count = exp_q.size();
		end
	end

	// receiver stalls only while bp_mode is set, stall drawn at the edge
	always @(posedge i_clk)
	begin
		bp_now = bp_mode && (($random(seed) & 1) == 0);
		#1;
		i_ready = !bp_now;
	end

	a_out_data: assert property (
		@(negedge i_clk) disable iff (i_reset)
		o_valid && i_ready |-> o_data == exp_head
	)
	else
	begin
		$display("CHECK FAILED at %0t o_data expected %h got %h", $time, exp_head, o_data);
		n_err = n_err + 1;
	end

	a_no_extra: assert property (
		@(negedge i_clk) disable iff (i_reset)
		o_valid |-> q_count > 0
	)
	else
	begin
		$display("output valid at %0t with no sample outstanding", $time);
		n_err = n_err + 1;
	end

	a_read: assert property (
		@(negedge i_clk) rd_en |-> o_cfg_rdata == rd_exp
	)
	else
	begin
		$display("CHECK FAILED at %0t o_cfg_rdata expected %h got %h", $time, rd_exp, o_cfg_rdata);
		n_err = n_err + 1;
	end

	a_value: assert property (
		@(negedge i_clk) cmp_en |-> cmp_got == cmp_exp
	)
	else
	begin
		$display("CHECK FAILED at %0t %s expected %0d got %0d", $time, cmp_name, cmp_exp, cmp_got);
		n_err = n_err + 1;
	end

	task automatic fail_timeout(string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("TEST FAIL");
		$finish;
	endtask

	// hold valid and data until the DUT takes the sample
	task automatic send(sample_t s);
		int   n;
		logic rdy;
		n = 0;
		rdy = 1'b0;
		i_valid = 1'b1;
		i_data = s;
		while (!rdy)
		begin
			rdy = o_ready;
			@(posedge i_clk);
			#1;
			n++;
			if (n > 1000)
			begin
				fail_timeout("o_ready");
			end
		end
		i_valid = 1'b0;
	endtask

	task automatic drain(string what);
		int n;
		n = 0;
		while (q_count != 0)
		begin
			@(posedge i_clk);
			#1;
			n++;
			if (n > 4000)
			begin
				fail_timeout(what);
			end
		end
	endtask

	task automatic cfg_write(cfg_addr_t a, logic [`STREAM_CFG_W-1:0] d);
		i_cfg_we = 1'b1;
		i_cfg_addr = a;
		i_cfg_wdata = d;
		@(posedge i_clk);
		#1;
		i_cfg_we = 1'b0;
		case (a)
			ADDR_GAIN:   cfg_gain = d[`STREAM_GAIN_W-1:0];
			ADDR_OFFSET: cfg_offset = sample_t'(d);
			ADDR_CTRL:   cfg_en = d[0];
			default:     exp_sat = 0;
		endcase
	endtask

	task automatic read_expect(cfg_addr_t a, logic [`STREAM_CFG_W-1:0] e);
		i_cfg_addr = a;
		rd_exp = e;
		rd_en = 1'b1;
		@(posedge i_clk);
		#1;
		rd_en = 1'b0;
	endtask

	task automatic compare(string name, int e, int g);
		cmp_name = name;
		cmp_exp = e;
		cmp_got = g;
		cmp_en = 1'b1;
		@(posedge i_clk);
		#1;
		cmp_en = 1'b0;
	endtask

	task automatic report_test(string name);
		$display("%s %s, %0d failed checks", name,
			(n_err == errs_at_start) ? "done" : "done with errors", n_err - errs_at_start);
		errs_at_start = n_err;
		n_tests++;
	endtask

	initial
	begin
		seed = 47120;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_data = '0;
		i_cfg_we = 1'b0;
		i_cfg_addr = ADDR_GAIN;
		i_cfg_wdata = '0;
		repeat (10) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		compare("o_valid", 0, int'(o_valid));
		compare("o_ready", 1, int'(o_ready));
		read_expect(ADDR_SATCNT, '0);
		send(16'sd1234);
		drain("the latency sample");
		compare("latency", 4, out_cyc - acc_cyc);
		report_test("reset_latency");

		// still in bypass from reset
		for (i = 0; i < 32; i++)
		begin
			send(sample_t'(i * 1000 - 16000));
		end
		drain("the bypass ramp");
		report_test("bypass");

		cfg_write(ADDR_GAIN, 16'h00a5);
		cfg_write(ADDR_OFFSET, 16'h8123);
		cfg_write(ADDR_CTRL, 16'h0001);
		read_expect(ADDR_GAIN, 16'h00a5);
		read_expect(ADDR_OFFSET, 16'h8123);
		read_expect(ADDR_CTRL, 16'h0001);
		report_test("readback");

		for (k = 0; k < 4; k++)
		begin
			cfg_write(ADDR_GAIN, gains[k]);
			cfg_write(ADDR_OFFSET, offsets[k]);
			for (i = 0; i < 24; i++)
			begin
				send(sample_t'($random(seed)));
			end
			drain("a scaling burst");
		end
		report_test("scaling");

		// large gain, offset +20000 then -20000
		cfg_write(ADDR_SATCNT, '0);
		cfg_write(ADDR_GAIN, 16'h00ff);
		cfg_write(ADDR_OFFSET, 16'h4e20);
		for (i = 0; i < 8; i++)
		begin
			if (i == 4)
			begin
				drain("the positive clamp burst");
				cfg_write(ADDR_OFFSET, 16'hb1e0);
			end
			send(extremes[i]);
		end
		drain("the negative clamp burst");
		read_expect(ADDR_SATCNT, `STREAM_CFG_W'(exp_sat));
		cfg_write(ADDR_SATCNT, '0);
		read_expect(ADDR_SATCNT, '0);
		report_test("saturation");

		cfg_write(ADDR_GAIN, 16'h0018);
		cfg_write(ADDR_OFFSET, 16'hfed4);
		bp_mode = 1'b1;
		for (i = 0; i < 200; i++)
		begin
			send(sample_t'($random(seed)));
		end
		drain("the back-pressure burst");
		bp_mode = 1'b0;
		compare("n_out", n_in, n_out);
		report_test("backpressure");

		$display("tests %0d, failed checks %0d, samples in %0d, samples out %0d",
			n_tests, n_err, n_in, n_out);
		if (n_err == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+design
design/stream_pkg.sv
design/skidbuffer.sv
design/sample_scaler.sv
design/scaler_regs.sv
design/scaler_top.sv
dv/scaler_tb.sv

// File: run.sh
#!/bin/sh
# build and run the scaler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module scaler_tb -o scaler_sim

output=$(./obj_dir/scaler_sim)
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
